// File: l1s_params.svh
/*
 Store buffer sizing. Strand count must stay a power of two,
 and the line must be a whole number of bytes.
*/
`ifndef L1S_PARAMS_SVH
`define L1S_PARAMS_SVH

// One store entry per hardware strand
`define L1S_NUM_STRANDS 4
`define L1S_STRAND_WIDTH 2

// Line address is {tag, set}
`define L1S_TAG_WIDTH 21
`define L1S_SET_WIDTH 5

`define L1S_LINE_BITS 512

// Unit number of the store buffer on the L2 buses
`define L1S_UNIT_WIDTH 2
`define L1S_STBUF_UNIT 2

`endif

// File: l1s_pkg.sv
/*
 Shared types of the L1 store buffer. Widths come from the params header.
*/
`default_nettype none

`include "l1s_params.svh"

package l1s_pkg;

	typedef logic [`L1S_STRAND_WIDTH-1:0] strand_id_t;
	typedef logic [`L1S_NUM_STRANDS-1:0] strand_vec_t;

	typedef logic [`L1S_TAG_WIDTH-1:0] tag_t;
	typedef logic [`L1S_SET_WIDTH-1:0] set_idx_t;

	// Tag in the upper bits, set in the lower bits
	typedef logic [`L1S_TAG_WIDTH+`L1S_SET_WIDTH-1:0] l2_addr_t;

	typedef logic [`L1S_LINE_BITS-1:0] line_data_t;

	// One enable per byte of the line
	typedef logic [`L1S_LINE_BITS/8-1:0] byte_mask_t;

	typedef logic [`L1S_UNIT_WIDTH-1:0] unit_id_t;

	// L2 request channel
	typedef enum logic
	{
		ISSUE_IDLE,
		ISSUE_WAIT_ACK
	} issue_state_t;

endpackage

`default_nettype wire

// File: stbuf_if.sv
/*
 Entry state and entry commands between the store buffer blocks.
 Every command here is a single-cycle strobe.
*/
`timescale 1ns/1ps
`default_nettype none

`include "l1s_params.svh"

interface stbuf_if import l1s_pkg::*; ();

	// Entry state, owned by the entry file
	strand_vec_t enqueued;
	strand_vec_t acknowledged;
	tag_t tag [`L1S_NUM_STRANDS];
	set_idx_t set [`L1S_NUM_STRANDS];
	line_data_t data [`L1S_NUM_STRANDS];
	byte_mask_t mask [`L1S_NUM_STRANDS];

	// Enqueue command from decode
	logic enq_en;
	strand_id_t enq_strand;
	tag_t enq_tag;
	set_idx_t enq_set;
	line_data_t enq_data;
	byte_mask_t enq_mask;
	// Write and completion hit the same strand together
	logic collision;

	// L2 accepted the request of ack_strand
	logic ack_en;
	strand_id_t ack_strand;

	// L2 finished the store of done_strand
	logic done_en;
	strand_id_t done_strand;

	modport entry_mp (
		output enqueued, acknowledged, tag, set, data, mask,
		input enq_en, enq_strand, enq_tag, enq_set, enq_data, enq_mask,
		input collision, ack_en, ack_strand, done_en, done_strand
	);

	modport decode_mp (
		input enqueued, tag, set, data, mask, done_en, done_strand,
		output enq_en, enq_strand, enq_tag, enq_set, enq_data, enq_mask, collision
	);

	modport issue_mp (
		input enqueued, acknowledged, tag, set, data, mask,
		output ack_en, ack_strand
	);

	modport complete_mp (
		input enqueued, set,
		output done_en, done_strand
	);

endinterface

`default_nettype wire

// File: store_request_decode.sv
/*
 Classifies pipeline accesses. A write to an occupied strand is dropped
 and flagged full, unless that entry completes in the same cycle.
*/
`timescale 1ns/1ps
`default_nettype none

`include "l1s_params.svh"

module store_request_decode import l1s_pkg::*; (
	input wire clk,
	input wire rst_n_i,

	input wire write_i,
	input wire tag_t tag_i,
	input wire set_idx_t set_i,
	input wire line_data_t data_i,
	input wire byte_mask_t mask_i,
	input wire strand_id_t strand_id_i,

	output line_data_t data_o,
	output byte_mask_t mask_o,
	output logic full_o,

	stbuf_if.decode_mp sb
);

	logic slot_busy;
	logic is_full;
	line_data_t raw_data;
	byte_mask_t raw_mask;

	// Slot frees up this cycle, so the new store takes it
	assign sb.collision = write_i && sb.done_en && (sb.done_strand == strand_id_i);

	assign slot_busy = sb.enqueued[strand_id_i];
	assign is_full = write_i && slot_busy && !sb.collision;

	assign sb.enq_en = write_i && (!slot_busy || sb.collision);
	assign sb.enq_strand = strand_id_i;
	assign sb.enq_tag = tag_i;
	assign sb.enq_set = set_i;
	assign sb.enq_data = data_i;
	assign sb.enq_mask = mask_i;

	// RAW bypass, only from the same strand
	always_comb
	begin
		raw_data = '0;
		raw_mask = '0;
		for (int j = 0; j < `L1S_NUM_STRANDS; j++)
		begin
			if (sb.enqueued[j] && sb.tag[j] == tag_i && sb.set[j] == set_i
				&& strand_id_t'(j) == strand_id_i)
			begin
				raw_data = sb.data[j];
				raw_mask = sb.mask[j];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			data_o <= '0;
			mask_o <= '0;
			full_o <= 1'b0;
		end
		else
		begin
			data_o <= raw_data;
			mask_o <= raw_mask;
			full_o <= is_full;
		end
	end

endmodule

`default_nettype wire

// File: store_entry_file.sv
/*
 Four store entries, one per strand. Payload fields hold their
 value only while enqueued is set.
*/
`timescale 1ns/1ps
`default_nettype none

`include "l1s_params.svh"

module store_entry_file import l1s_pkg::*; (
	input wire clk,
	input wire rst_n_i,

	stbuf_if.entry_mp sb
);

	strand_vec_t enq_vec;
	strand_vec_t ack_vec;
	strand_vec_t done_vec;
	strand_vec_t retire_vec;

	assign enq_vec = sb.enq_en ? (strand_vec_t'(1) << sb.enq_strand) : '0;
	assign ack_vec = sb.ack_en ? (strand_vec_t'(1) << sb.ack_strand) : '0;
	assign done_vec = sb.done_en ? (strand_vec_t'(1) << sb.done_strand) : '0;

	// On a collision the entry stays valid and takes the new store
	assign retire_vec = sb.collision ? '0 : done_vec;

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			sb.enqueued <= '0;
			sb.acknowledged <= '0;
		end
		else
		begin
			sb.enqueued <= (sb.enqueued & ~retire_vec) | enq_vec;
			sb.acknowledged <= (sb.acknowledged | ack_vec) & ~done_vec;
		end
	end

	always_ff @(posedge clk)
	begin
		if (sb.enq_en)
		begin
			sb.tag[sb.enq_strand] <= sb.enq_tag;
			sb.set[sb.enq_strand] <= sb.enq_set;
			sb.data[sb.enq_strand] <= sb.enq_data;
			sb.mask[sb.enq_strand] <= sb.enq_mask;
		end
	end

endmodule

`default_nettype wire

// File: store_issue_unit.sv
/*
 Sends pending stores to the L2 one at a time. Valid holds until ack,
 then one idle cycle passes before the next request.
*/
`timescale 1ns/1ps
`default_nettype none

`include "l1s_params.svh"

module store_issue_unit import l1s_pkg::*; (
	input wire clk,
	input wire rst_n_i,

	input wire pci_ack_i,
	output logic pci_valid_o,
	output strand_id_t pci_strand_o,
	output l2_addr_t pci_address_o,
	output line_data_t pci_data_o,
	output byte_mask_t pci_mask_o,

	stbuf_if.issue_mp sb
);

	issue_state_t state_q;
	strand_id_t issue_strand_q;
	strand_id_t last_grant_q;
	strand_vec_t req_vec;
	strand_id_t cand;
	strand_id_t grant_strand;
	logic grant_valid;

	// Pending and not yet taken by the L2
	assign req_vec = sb.enqueued & ~sb.acknowledged;

	// Rotating priority, search starts after the last granted strand
	always_comb
	begin
		grant_valid = 1'b0;
		grant_strand = last_grant_q;
		cand = last_grant_q;
		for (int off = 1; off <= `L1S_NUM_STRANDS; off++)
		begin
			cand = strand_id_t'(last_grant_q + off);
			if (!grant_valid && req_vec[cand])
			begin
				grant_valid = 1'b1;
				grant_strand = cand;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			state_q <= ISSUE_IDLE;
			issue_strand_q <= '0;
			last_grant_q <= '1;
		end
		else
		begin
			case (state_q)
				ISSUE_IDLE:
				begin
					if (grant_valid)
					begin
						issue_strand_q <= grant_strand;
						last_grant_q <= grant_strand;
						state_q <= ISSUE_WAIT_ACK;
					end
				end
				ISSUE_WAIT_ACK:
				begin
					if (pci_ack_i)
						state_q <= ISSUE_IDLE;
				end
				default: state_q <= ISSUE_IDLE;
			endcase
		end
	end

	assign pci_valid_o = (state_q == ISSUE_WAIT_ACK);
	assign pci_strand_o = issue_strand_q;
	assign pci_address_o = {sb.tag[issue_strand_q], sb.set[issue_strand_q]};
	assign pci_data_o = sb.data[issue_strand_q];
	assign pci_mask_o = sb.mask[issue_strand_q];

	assign sb.ack_en = pci_valid_o && pci_ack_i;
	assign sb.ack_strand = issue_strand_q;

endmodule

`default_nettype wire

// File: store_completion_unit.sv
/*
 Retires entries on L2 completions and wakes strands that were
 suspended on a full slot. Other units on the bus are ignored.
*/
`timescale 1ns/1ps
`default_nettype none

`include "l1s_params.svh"

module store_completion_unit import l1s_pkg::*; (
	input wire clk,
	input wire rst_n_i,

	input wire cpi_valid_i,
	input wire unit_id_t cpi_unit_i,
	input wire strand_id_t cpi_strand_i,
	input wire cpi_update_i,

	output logic store_update_o,
	output set_idx_t store_update_set_o,
	output strand_vec_t resume_strands_o,

	// Full flag and the strand it belongs to, both one cycle late
	input wire full_o,
	input wire strand_id_t strand_id_i,

	stbuf_if.complete_mp sb
);

	strand_vec_t wait_q;
	strand_vec_t wait_now;
	strand_vec_t done_vec;

	assign sb.done_en = cpi_valid_i && (cpi_unit_i == unit_id_t'(`L1S_STBUF_UNIT))
		&& sb.enqueued[cpi_strand_i];
	assign sb.done_strand = cpi_strand_i;

	assign store_update_o = sb.done_en && cpi_update_i;
	assign store_update_set_o = sb.done_en ? sb.set[cpi_strand_i] : '0;

	assign done_vec = sb.done_en ? (strand_vec_t'(1) << cpi_strand_i) : '0;

	// A strand flagged this cycle counts as waiting already
	assign wait_now = wait_q | (full_o ? (strand_vec_t'(1) << strand_id_i) : '0);

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			wait_q <= '0;
			resume_strands_o <= '0;
		end
		else
		begin
			wait_q <= wait_now & ~done_vec;
			resume_strands_o <= wait_now & done_vec;
		end
	end

endmodule

`default_nettype wire

// File: store_buffer_top.sv
/*
 Store buffer for four strands. The L2 side supplies the request
 op and way fields, and completion data is not consumed.
*/
`timescale 1ns/1ps
`default_nettype none

`include "l1s_params.svh"

module store_buffer_top import l1s_pkg::*; (
	input wire clk,
	input wire rst_n_i,

	// Pipeline access
	input wire write_i,
	input wire tag_t tag_i,
	input wire set_idx_t set_i,
	input wire line_data_t data_i,
	input wire byte_mask_t mask_i,
	input wire strand_id_t strand_id_i,

	// Bypass and suspend
	output line_data_t data_o,
	output byte_mask_t mask_o,
	output logic full_o,

	// L2 request
	output logic pci_valid_o,
	input wire pci_ack_i,
	output strand_id_t pci_strand_o,
	output l2_addr_t pci_address_o,
	output line_data_t pci_data_o,
	output byte_mask_t pci_mask_o,

	// L2 completion
	input wire cpi_valid_i,
	input wire unit_id_t cpi_unit_i,
	input wire strand_id_t cpi_strand_i,
	input wire cpi_update_i,

	output logic store_update_o,
	output set_idx_t store_update_set_o,
	output strand_vec_t resume_strands_o
);

	stbuf_if sb ();

	strand_id_t full_strand_q;

	// Lines up with full_o, which the decode registers
	always_ff @(posedge clk)
	begin
		full_strand_q <= strand_id_i;
	end

	store_request_decode i_decode (
		.clk (clk),
		.rst_n_i (rst_n_i),
		.write_i (write_i),
		.tag_i (tag_i),
		.set_i (set_i),
		.data_i (data_i),
		.mask_i (mask_i),
		.strand_id_i (strand_id_i),
		.data_o (data_o),
		.mask_o (mask_o),
		.full_o (full_o),
		.sb (sb.decode_mp)
	);

	store_entry_file i_entries (
		.clk (clk),
		.rst_n_i (rst_n_i),
		.sb (sb.entry_mp)
	);

	store_issue_unit i_issue (
		.clk (clk),
		.rst_n_i (rst_n_i),
		.pci_ack_i (pci_ack_i),
		.pci_valid_o (pci_valid_o),
		.pci_strand_o (pci_strand_o),
		.pci_address_o (pci_address_o),
		.pci_data_o (pci_data_o),
		.pci_mask_o (pci_mask_o),
		.sb (sb.issue_mp)
	);

	store_completion_unit i_complete (
		.clk (clk),
		.rst_n_i (rst_n_i),
		.cpi_valid_i (cpi_valid_i),
		.cpi_unit_i (cpi_unit_i),
		.cpi_strand_i (cpi_strand_i),
		.cpi_update_i (cpi_update_i),
		.store_update_o (store_update_o),
		.store_update_set_o (store_update_set_o),
		.resume_strands_o (resume_strands_o),
		.full_o (full_o),
		.strand_id_i (full_strand_q),
		.sb (sb.complete_mp)
	);

endmodule

`default_nettype wire

// File: tb_l2_responder.sv
/*
 Behavioral L2 for the store buffer testbench. Acks after 0 to 3 cycles,
 completes in ack order, and holds completions while hold_i is high.
 Idle cycles may carry a completion strobe addressed to another unit.
*/
`timescale 1ns/1ps
`default_nettype none

`include "l1s_params.svh"

module tb_l2_responder import l1s_pkg::*; (
	input wire clk,
	input wire rst_n_i,
	input wire hold_i,

	input wire pci_valid_i,
	input wire strand_id_t pci_strand_i,
	output logic pci_ack_o,

	output logic cpi_valid_o,
	output unit_id_t cpi_unit_o,
	output strand_id_t cpi_strand_o,
	output logic cpi_update_o,

	output int ack_count_o,
	output logic ready_o
);

	strand_id_t pending [$];
	logic armed;
	int ack_delay;
	int cmpl_delay;

	initial
	begin
		pci_ack_o = 1'b0;
		cpi_valid_o = 1'b0;
		cpi_unit_o = unit_id_t'(`L1S_STBUF_UNIT);
		cpi_strand_o = '0;
		cpi_update_o = 1'b1;
		ack_count_o = 0;
		ready_o = 1'b0;
	end

	always @(negedge clk)
	begin
		if (!rst_n_i)
		begin
			pci_ack_o <= 1'b0;
			cpi_valid_o <= 1'b0;
			ack_count_o <= 0;
			ready_o <= 1'b0;
			armed = 1'b0;
			cmpl_delay = 0;
			pending.delete();
		end
		else
		begin
			pci_ack_o <= 1'b0;
			cpi_valid_o <= 1'b0;
			if (pci_valid_i)
			begin
				if (!armed)
				begin
					armed = 1'b1;
					ack_delay = $urandom_range(0, 3);
				end
				if (ack_delay == 0)
				begin
					pci_ack_o <= 1'b1;
					armed = 1'b0;
					ack_count_o <= ack_count_o + 1;
					if (pending.size() == 0)
						cmpl_delay = $urandom_range(1, 4);
					pending.push_back(pci_strand_i);
				end
				else
					ack_delay--;
			end
			// Completions leave in the order the requests were acked
			if (cmpl_delay > 0)
				cmpl_delay--;
			else if (pending.size() > 0 && !hold_i)
			begin
				cpi_valid_o <= 1'b1;
				cpi_unit_o <= unit_id_t'(`L1S_STBUF_UNIT);
				cpi_strand_o <= pending.pop_front();
				if (pending.size() > 0)
					cmpl_delay = $urandom_range(1, 4);
			end
			else if ($urandom_range(0, 3) == 0)
			begin
				// Another unit shares the bus, the buffer must ignore it
				cpi_valid_o <= 1'b1;
				cpi_unit_o <= unit_id_t'(`L1S_STBUF_UNIT + 1);
				cpi_strand_o <= strand_id_t'($urandom_range(0, 3));
			end
			ready_o <= (pending.size() > 0) && (cmpl_delay == 0);
		end
	end

endmodule

`default_nettype wire

// File: tb_store_buffer.sv
/*
 Testbench for store_buffer_top. A shadow model of the four entries
 is checked every cycle; directed phases then random traffic.
*/
`timescale 1ns/1ps
`default_nettype none

`include "l1s_params.svh"

module tb_store_buffer import l1s_pkg::*; ();

	logic clk = 1'b0;
	logic rst_n_i;
	logic write_i;
	tag_t tag_i;
	set_idx_t set_i;
	line_data_t data_i;
	byte_mask_t mask_i;
	strand_id_t strand_id_i;
	line_data_t data_o;
	byte_mask_t mask_o;
	logic full_o;
	logic pci_valid_o;
	logic pci_ack_i;
	strand_id_t pci_strand_o;
	l2_addr_t pci_address_o;
	line_data_t pci_data_o;
	byte_mask_t pci_mask_o;
	logic cpi_valid_i;
	unit_id_t cpi_unit_i;
	strand_id_t cpi_strand_i;
	logic cpi_update_i;
	logic store_update_o;
	set_idx_t store_update_set_o;
	strand_vec_t resume_strands_o;
	logic hold_cmpl;
	int ack_count;
	logic cmpl_ready;
	int err_count = 0;

	// Shadow entries and the expectations for the next cycle
	strand_vec_t m_valid;
	strand_vec_t m_wait;
	tag_t m_tag [`L1S_NUM_STRANDS];
	set_idx_t m_set [`L1S_NUM_STRANDS];
	line_data_t m_data [`L1S_NUM_STRANDS];
	byte_mask_t m_mask [`L1S_NUM_STRANDS];
	logic exp_full_q;
	strand_id_t exp_full_strand_q;
	line_data_t exp_data_q;
	byte_mask_t exp_mask_q;
	strand_vec_t exp_resume_q;
	logic prev_valid;
	logic prev_ack;
	strand_id_t prev_strand;
	l2_addr_t prev_addr;
	line_data_t prev_data;
	byte_mask_t prev_mask;
	strand_id_t issue_log [$];

	always #10 clk = ~clk;

	store_buffer_top i_dut (.*);

	tb_l2_responder i_l2 (
		.clk (clk),
		.rst_n_i (rst_n_i),
		.hold_i (hold_cmpl),
		.pci_valid_i (pci_valid_o),
		.pci_strand_i (pci_strand_o),
		.pci_ack_o (pci_ack_i),
		.cpi_valid_o (cpi_valid_i),
		.cpi_unit_o (cpi_unit_i),
		.cpi_strand_o (cpi_strand_i),
		.cpi_update_o (cpi_update_i),
		.ack_count_o (ack_count),
		.ready_o (cmpl_ready)
	);

	task automatic report_value(input string name, input logic [511:0] got,
		input logic [511:0] exp);
		err_count++;
		$display("Fail %s: got %0h, expected %0h", name, got, exp);
		$display("Simulation finished: FAIL");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic report_error(input string msg);
		err_count++;
		$display("Error: %s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "%s", msg);
	endtask

	function automatic line_data_t rand_line();
		line_data_t v;
		for (int i = 0; i < `L1S_LINE_BITS / 32; i++)
			v[i*32 +: 32] = $urandom;
		return v;
	endfunction

	// One pipeline access per cycle, a write or a lookup
	task automatic access(input logic wr, input strand_id_t s, input tag_t t,
		input set_idx_t st, input line_data_t d, input byte_mask_t m);
		@(negedge clk);
		write_i <= wr;
		strand_id_i <= s;
		tag_i <= t;
		set_i <= st;
		data_i <= d;
		mask_i <= m;
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		write_i <= 1'b0;
	endtask

	task automatic set_hold(input logic h);
		@(negedge clk);
		hold_cmpl <= h;
	endtask

	task automatic wait_idle();
		int n;
		for (n = 0; n < 200; n++)
		begin
			@(posedge clk);
			if (m_valid == '0)
				break;
		end
		if (n == 200)
			report_error("store buffer did not drain within 200 cycles");
	endtask

	task automatic wait_acks(input int target);
		int n;
		for (n = 0; n < 200; n++)
		begin
			@(posedge clk);
			if (ack_count >= target)
				break;
		end
		if (n == 200)
			report_error("L2 requests were not acknowledged within 200 cycles");
	endtask

	task automatic wait_ready();
		int n;
		for (n = 0; n < 200; n++)
		begin
			@(posedge clk);
			if (cmpl_ready)
				break;
		end
		if (n == 200)
			report_error("no completion became ready within 200 cycles");
	endtask

	always @(posedge clk)
	begin : monitor
		logic done;
		logic full_now;
		strand_vec_t done_vec;
		strand_vec_t wait_now;
		strand_id_t s;
		if (!rst_n_i)
		begin
			m_valid <= '0;
			m_wait <= '0;
			exp_full_q <= 1'b0;
			exp_full_strand_q <= '0;
			exp_data_q <= '0;
			exp_mask_q <= '0;
			exp_resume_q <= '0;
			prev_valid <= 1'b0;
			prev_ack <= 1'b0;
		end
		else
		begin
			s = strand_id_i;
			assert (full_o == exp_full_q) else report_value("full_o", full_o, exp_full_q);
			assert (data_o == exp_data_q) else report_value("data_o", data_o, exp_data_q);
			assert (mask_o == exp_mask_q) else report_value("mask_o", mask_o, exp_mask_q);
			assert (resume_strands_o == exp_resume_q)
				else report_value("resume_strands_o", resume_strands_o, exp_resume_q);

			done = cpi_valid_i && cpi_unit_i == unit_id_t'(`L1S_STBUF_UNIT)
				&& m_valid[cpi_strand_i];
			assert (store_update_o == (done && cpi_update_i))
				else report_value("store_update_o", store_update_o, done && cpi_update_i);
			if (done)
				assert (store_update_set_o == m_set[cpi_strand_i])
					else report_value("store_update_set_o", store_update_set_o,
						m_set[cpi_strand_i]);

			// Request carries the shadow entry and holds until ack
			if (pci_valid_o)
			begin
				assert (m_valid[pci_strand_o])
					else report_error("L2 request issued for a strand with no pending store");
				assert (pci_address_o == {m_tag[pci_strand_o], m_set[pci_strand_o]})
					else report_value("pci_address_o", pci_address_o,
						{m_tag[pci_strand_o], m_set[pci_strand_o]});
				assert (pci_data_o == m_data[pci_strand_o])
					else report_value("pci_data_o", pci_data_o, m_data[pci_strand_o]);
				assert (pci_mask_o == m_mask[pci_strand_o])
					else report_value("pci_mask_o", pci_mask_o, m_mask[pci_strand_o]);
			end
			if (prev_valid && !prev_ack)
				assert (pci_valid_o && pci_strand_o == prev_strand && pci_address_o == prev_addr
					&& pci_data_o == prev_data && pci_mask_o == prev_mask)
					else report_error("L2 request changed before it was acknowledged");
			if (prev_valid && prev_ack)
				assert (!pci_valid_o) else report_value("pci_valid_o", pci_valid_o, 1'b0);

			if (m_valid[s] && m_tag[s] == tag_i && m_set[s] == set_i)
			begin
				exp_data_q <= m_data[s];
				exp_mask_q <= m_mask[s];
			end
			else
			begin
				exp_data_q <= '0;
				exp_mask_q <= '0;
			end

			full_now = write_i && m_valid[s] && !(done && cpi_strand_i == s);
			exp_full_q <= full_now;
			exp_full_strand_q <= s;
			wait_now = m_wait | (exp_full_q ? strand_vec_t'(1) << exp_full_strand_q : '0);
			done_vec = done ? strand_vec_t'(1) << cpi_strand_i : '0;
			m_wait <= wait_now & ~done_vec;
			exp_resume_q <= wait_now & done_vec;

			// Retire first so a write in the same cycle wins
			if (done)
				m_valid[cpi_strand_i] <= 1'b0;
			if (write_i && !full_now)
			begin
				m_valid[s] <= 1'b1;
				m_tag[s] <= tag_i;
				m_set[s] <= set_i;
				m_data[s] <= data_i;
				m_mask[s] <= mask_i;
			end

			if (pci_valid_o && pci_ack_i)
				issue_log.push_back(pci_strand_o);
			prev_valid <= pci_valid_o;
			prev_ack <= pci_ack_i;
			prev_strand <= pci_strand_o;
			prev_addr <= pci_address_o;
			prev_data <= pci_data_o;
			prev_mask <= pci_mask_o;
		end
	end

	initial
	begin
		int seed;
		int base;
		tag_t t;
		set_idx_t st;
		strand_vec_t seen;
		seed = $urandom(32'h4e89b2f3);
		rst_n_i = 1'b0;
		write_i = 1'b0;
		tag_i = '0;
		set_i = '0;
		data_i = '0;
		mask_i = '0;
		strand_id_i = '0;
		hold_cmpl = 1'b0;
		repeat (5) @(negedge clk);
		rst_n_i <= 1'b1;
		@(posedge clk);
		assert (!pci_valid_o && !full_o && !store_update_o && resume_strands_o == '0
			&& data_o == '0 && mask_o == '0)
			else report_error("outputs were not cleared by reset");

		// Store, then bypass lookups from the same and other strands
		set_hold(1'b1);
		for (int s = 0; s < `L1S_NUM_STRANDS; s++)
		begin
			t = $urandom;
			st = $urandom;
			access(1'b1, s, t, st, rand_line(), {$urandom, $urandom});
			access(1'b0, s, t, st, '0, '0);
			access(1'b0, strand_id_t'(s + 1), t, st, '0, '0);
			access(1'b0, s, t ^ 1, st, '0, '0);
		end
		idle_cycle();
		set_hold(1'b0);
		wait_idle();

		// Second write to an occupied strand
		set_hold(1'b1);
		access(1'b1, 2, $urandom, $urandom, rand_line(), {$urandom, $urandom});
		access(1'b1, 2, $urandom, $urandom, rand_line(), {$urandom, $urandom});
		idle_cycle();
		set_hold(1'b0);
		wait_idle();

		// Write lands in the cycle its own entry completes
		set_hold(1'b1);
		access(1'b1, 1, $urandom, $urandom, rand_line(), {$urandom, $urandom});
		idle_cycle();
		wait_ready();
		set_hold(1'b0);
		access(1'b1, 1, $urandom, $urandom, rand_line(), {$urandom, $urandom});
		@(posedge clk);
		assert (cpi_valid_i && cpi_strand_i == 1
			&& cpi_unit_i == unit_id_t'(`L1S_STBUF_UNIT))
			else report_error("completion did not line up with the write");
		idle_cycle();
		wait_idle();

		// All four pending, completions held
		set_hold(1'b1);
		base = ack_count;
		for (int s = 0; s < `L1S_NUM_STRANDS; s++)
			access(1'b1, s, $urandom, $urandom, rand_line(), {$urandom, $urandom});
		idle_cycle();
		wait_acks(base + `L1S_NUM_STRANDS);
		@(negedge clk);
		seen = '0;
		for (int i = issue_log.size() - `L1S_NUM_STRANDS; i < issue_log.size(); i++)
			seen[issue_log[i]] = 1'b1;
		assert (seen == '1) else report_value("issued strand set", seen, 4'hf);
		set_hold(1'b0);
		wait_idle();

		// Random mix on two addresses so lookups hit
		repeat (80)
			access($urandom_range(0, 1), $urandom_range(0, 3), $urandom_range(0, 1), 5'h3,
				rand_line(), {$urandom, $urandom});
		idle_cycle();
		wait_idle();

		if (err_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
l1s_pkg.sv
stbuf_if.sv
store_request_decode.sv
store_entry_file.sv
store_issue_unit.sv
store_completion_unit.sv
store_buffer_top.sv
tb_l2_responder.sv
tb_store_buffer.sv

// File: Bender.yml
package:
  name: l1_store_buffer

export_include_dirs:
  - .

sources:
  - l1s_pkg.sv
  - stbuf_if.sv
  - store_request_decode.sv
  - store_entry_file.sv
  - store_issue_unit.sv
  - store_completion_unit.sv
  - store_buffer_top.sv
  - target: simulation
    files:
      - tb_l2_responder.sv
      - tb_store_buffer.sv
